/* dram_hash_patterns.txt */
// Columns: test number, write flag, cache-side address, write data, expected read data
// All values hex; writes expect zero data in the response
1 1 2a8 deadbeef 00000000
1 0 2a8 00000000 deadbeef
2 1 f41 12345678 00000000
2 1 07f cafef00d 00000000
3 1 410 11110000 00000000
3 1 450 22220001 00000000
3 1 490 33330002 00000000
3 0 410 00000000 11110000
3 0 450 00000000 22220001
3 0 490 00000000 33330002
4 1 638 a5a5a5a5 00000000
4 0 638 00000000 a5a5a5a5
4 1 638 5a5a5a5a 00000000
4 0 638 00000000 5a5a5a5a
5 1 140 0000aaaa 00000000
5 1 340 0000bbbb 00000000
5 1 160 0000cccc 00000000
5 1 150 0000dddd 00000000
5 1 148 0000eeee 00000000
5 0 140 00000000 0000aaaa
5 0 340 00000000 0000bbbb
5 0 160 00000000 0000cccc
5 0 150 00000000 0000dddd
5 0 148 00000000 0000eeee

/* filelist.f */
dram_addr_pkg.sv
dram_req_pkg.sv
dram_chan_if.sv
dram_hash_encode.sv
dram_hash_decode.sv
dram_req_dispatch.sv
dram_channel.sv
dram_resp_merge.sv
dram_hash_top.sv
dram_hash_tb.sv

/* dram_hash_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the hashed DRAM path
// Plays the directed patterns from the pattern file, then a seeded random phase
// Each response is checked against a queue of expected values and its latency
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dram_hash_tb;

  localparam int aw_lp       = dram_addr_pkg::daddr_width_lp;  // Address width
  localparam int dw_lp       = dram_req_pkg::data_width_lp;    // Data width
  localparam int num_pat_lp  = 24;   // Lines in the pattern file
  localparam int pat_cols_lp = 5;    // Test, write flag, address, write data, read data
  localparam int num_rand_lp = 200;  // Requests in the random phase
  localparam int latency_lp  = 3;    // Sampling edge to response in cycles
  localparam int margin_lp   = 50;   // Slack for reset and draining between tests

  logic             clk_i;
  logic             reset_i;
  logic             req_v_i;
  logic             req_we_i;
  logic [aw_lp-1:0] req_addr_i;
  logic [dw_lp-1:0] req_data_i;
  logic             resp_v_o;
  logic             resp_we_o;
  logic [aw_lp-1:0] resp_addr_o;
  logic [dw_lp-1:0] resp_data_o;

  logic [31:0]      pat_mem [num_pat_lp*pat_cols_lp];  // Whole pattern file with five words a line
  logic             exp_we_q [$];    // Expected write flag per request
  logic [aw_lp-1:0] exp_addr_q [$];  // Expected address which is always the request address
  logic [dw_lp-1:0] exp_data_q [$];  // Expected data which is zero for writes
  int               issue_q [$];     // Cycle in which each request was on the inputs
  logic [dw_lp-1:0] model [logic [aw_lp-4:0]];  // Reference memory keyed without offset
  logic [aw_lp-1:0] written_q [$];   // Addresses written in the random phase
  int               cycle_cnt = 0;   // Falling edges since time zero
  int               cycle_limit;     // Run is stopped past this cycle
  int               pass_cnt = 0;
  int               fail_cnt = 0;
  int               test_fail_base;  // Failures seen before the current test

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;  // 4 ns period

  dram_hash_top UUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .resp_v_o    (resp_v_o),
    .resp_we_o   (resp_we_o),
    .resp_addr_o (resp_addr_o),
    .resp_data_o (resp_data_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  function automatic string test_name(input int t);
    case (t)
      1:       return "write then read of one address";
      2:       return "write responses";
      3:       return "set bits pick separate channels";
      4:       return "back-to-back write and read";
      5:       return "tag bank slice and CCE do not alias";
      6:       return "random mix against reference model";
      default: return "unnamed test";
    endcase
  endfunction

  // Puts one request on the inputs for a cycle and queues what must come back
  task automatic send_req(input logic we, input logic [aw_lp-1:0] addr,
                          input logic [dw_lp-1:0] wdata, input logic [dw_lp-1:0] rdata);
    @(posedge clk_i);
    req_v_i    <= 1'b1;
    req_we_i   <= we;
    req_addr_i <= addr;
    req_data_i <= wdata;
    exp_we_q.push_back(we);
    exp_addr_q.push_back(addr);          // Decode must undo the encode
    exp_data_q.push_back(we ? '0 : rdata);
  endtask

  // Stops issuing, waits a bounded time for the queue to empty and reports the test
  task automatic finish_test(input int t);
    int waited;
    waited = 0;
    @(posedge clk_i);
    req_v_i <= 1'b0;
    while (exp_we_q.size() != 0 && waited < latency_lp + 2) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_we_q.size() != 0) begin
      $display("Test %0d ended with %0d requests that never got a response", t,
               exp_we_q.size());
      fail_cnt++;
      exp_we_q.delete();   // Later tests start from an empty queue
      exp_addr_q.delete();
      exp_data_q.delete();
      issue_q.delete();
    end
    $display("Test %0d (%s) done with %0d failed checks", t, test_name(t),
             fail_cnt - test_fail_base);
    test_fail_base = fail_cnt;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Response monitor
  // ~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk_i) begin
    logic             we;
    logic [aw_lp-1:0] addr;
    logic [dw_lp-1:0] data;
    int               issued;
    cycle_cnt++;
    if (req_v_i === 1'b1) begin
      issue_q.push_back(cycle_cnt);  // Sampled by the DUT on the next rising edge
    end
    if (resp_v_o === 1'b1) begin
      if (exp_we_q.size() == 0 || issue_q.size() == 0) begin
        $display("Response at %0t ns arrived with no request pending", $time);
        fail_cnt++;
      end else begin
        we     = exp_we_q.pop_front();
        addr   = exp_addr_q.pop_front();
        data   = exp_data_q.pop_front();
        issued = issue_q.pop_front();
        check_value(resp_we_o, we, "response write flag");
        check_value(resp_addr_o, addr, "response address");
        check_value(resp_data_o, data, "response data");
        check_value(cycle_cnt, issued + latency_lp, "response cycle");
      end
    end
    if (cycle_cnt > cycle_limit) begin
      $display("Run stopped at the cycle limit after %0d cycles", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    int               cur_test;
    logic             file_bad;
    logic [aw_lp-1:0] addr;
    logic [dw_lp-1:0] data;
    logic             do_read;
    void'($urandom(32'h70b86a34));  // One seed for the whole run
    cycle_limit    = num_pat_lp + num_rand_lp + latency_lp + margin_lp;
    test_fail_base = 0;
    file_bad       = 1'b0;
    reset_i    = 1'b1;
    req_v_i    = 1'b0;
    req_we_i   = 1'b0;
    req_addr_i = '0;
    req_data_i = '0;
    $readmemh("dram_hash_patterns.txt", pat_mem);
    for (int i = 0; i < num_pat_lp * pat_cols_lp; i++) begin
      if ($isunknown(pat_mem[i])) begin
        file_bad = 1'b1;  // Missing or short file leaves X words
      end
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // Directed patterns with one test per run of equal test numbers
    if (file_bad) begin
      $display("Pattern file dram_hash_patterns.txt could not be read in full");
      fail_cnt++;
    end else begin
      cur_test = pat_mem[0];
      for (int i = 0; i < num_pat_lp; i++) begin
        if (pat_mem[i*pat_cols_lp] != cur_test) begin
          finish_test(cur_test);
          cur_test = pat_mem[i*pat_cols_lp];
        end
        send_req(pat_mem[i*pat_cols_lp+1][0], pat_mem[i*pat_cols_lp+2][aw_lp-1:0],
                 pat_mem[i*pat_cols_lp+3], pat_mem[i*pat_cols_lp+4]);
      end
      finish_test(cur_test);
    end

    // Random mix where reads only go to words that hold a known value
    for (int n = 0; n < num_rand_lp; n++) begin
      do_read = ($urandom % 2 == 1) && (written_q.size() != 0);
      if (do_read) begin
        addr      = written_q[$urandom % written_q.size()];
        addr[2:0] = $urandom;  // Byte offset does not select a different word
        send_req(1'b0, addr, $urandom, model[addr[aw_lp-1:3]]);
      end else begin
        addr = $urandom;
        data = $urandom;
        model[addr[aw_lp-1:3]] = data;
        written_q.push_back(addr);
        send_req(1'b1, addr, data, '0);
      end
    end
    finish_test(6);

    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* dram_hash_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Top of the hashed DRAM path with plain ports
// Dispatcher, four channels and merger give a fixed three cycle latency
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dram_hash_top (
  input  logic                                       clk_i,        // Core clock
  input  logic                                       reset_i,      // Sync reset, active high
  input  logic                                       req_v_i,      // Request strobe
  input  logic                                       req_we_i,     // Write flag
  input  logic [dram_addr_pkg::daddr_width_lp-1:0]   req_addr_i,   // Cache layout address
  input  logic [dram_req_pkg::data_width_lp-1:0]     req_data_i,   // Write data
  output logic                                       resp_v_o,     // Response strobe
  output logic                                       resp_we_o,    // Write flag echo
  output logic [dram_addr_pkg::daddr_width_lp-1:0]   resp_addr_o,  // Cache layout address
  output logic [dram_req_pkg::data_width_lp-1:0]     resp_data_o   // Read data or zero
);

  import dram_addr_pkg::*;
  import dram_req_pkg::*;

  daddr_u req_addr_u;   // Request address as a union
  daddr_u resp_addr_u;  // Response address as a union

  assign req_addr_u  = req_addr_i;   // Plain bits into the two-view word
  assign resp_addr_o = resp_addr_u;  // And back out as plain bits

  dram_chan_if chan_if [num_chan_lp] ();  // One bundle per channel

  // ~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~
  dram_req_dispatch dispatch (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_v_i    (req_v_i),
    .req_we_i   (req_we_i),
    .req_addr_i (req_addr_u),
    .req_data_i (req_data_i),
    .chan_o     (chan_if)
  );

  for (genvar i = 0; i < num_chan_lp; i++) begin : g_chan
    dram_channel channel (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .chan_io (chan_if[i])
    );
  end

  dram_resp_merge merge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .chan_i      (chan_if),
    .resp_v_o    (resp_v_o),
    .resp_we_o   (resp_we_o),
    .resp_addr_o (resp_addr_u),
    .resp_data_o (resp_data_o)
  );

endmodule

/* dram_resp_merge.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Response merger behind the memory channels
// ORs the one valid channel response, unhashes its address and registers it
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dram_resp_merge (
  input  logic                                   clk_i,        // Core clock
  input  logic                                   reset_i,      // Sync reset, active high
  dram_chan_if.merge                             chan_i [dram_req_pkg::num_chan_lp],
  output logic                                   resp_v_o,     // Response strobe
  output logic                                   resp_we_o,    // Write flag echo
  output dram_addr_pkg::daddr_u                  resp_addr_o,  // Cache layout address
  output logic [dram_req_pkg::data_width_lp-1:0] resp_data_o   // Read data or zero
);

  import dram_addr_pkg::*;
  import dram_req_pkg::*;

  logic [num_chan_lp-1:0]     v_vec;     // Valid of every channel
  logic [num_chan_lp-1:0]     we_vec;    // Gated write flags
  daddr_u                     addr_vec [num_chan_lp];  // Gated addresses
  logic [data_width_lp-1:0]   data_vec [num_chan_lp];  // Gated read data
  daddr_u                     sel_addr;  // Merged DRAM layout address
  logic [data_width_lp-1:0]   sel_data;  // Merged data
  daddr_u                     dec_addr;  // Merged address in cache layout

  // ~~~~~~~~~~~~~~~~~~~~
  // Gate each channel by its own valid
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < num_chan_lp; i++) begin : g_gate
    assign v_vec[i]    = chan_i[i].resp_v;
    assign we_vec[i]   = chan_i[i].resp_v & chan_i[i].resp_we;
    assign addr_vec[i] = {daddr_width_lp{chan_i[i].resp_v}} & chan_i[i].resp_addr;
    assign data_vec[i] = {data_width_lp{chan_i[i].resp_v}} & chan_i[i].resp_data;
  end

  // At most one channel is valid, so an OR picks it out
  always_comb begin
    sel_addr = '0;
    sel_data = '0;
    for (int i = 0; i < num_chan_lp; i++) begin
      sel_addr = sel_addr | addr_vec[i];
      sel_data = sel_data | data_vec[i];
    end
  end

  dram_hash_decode decode (
    .addr_i (sel_addr),
    .addr_o (dec_addr)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Output registers
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= |v_vec;  // Any channel response becomes an output response
    end
  end

  always_ff @(posedge clk_i) begin
    resp_we_o   <= |we_vec;   // Payload rides along with the strobe
    resp_addr_o <= dec_addr;  // Requester sees its own address again
    resp_data_o <= sel_data;
  end

endmodule

/* dram_channel.sv */
// ~~~~~~~~~~~~~~~~~~~~
// One memory channel modelled as a synchronous word store
// Reads or writes in a single cycle and registers a one-cycle response
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dram_channel (
  input  logic     clk_i,    // Core clock
  input  logic     reset_i,  // Sync reset, active high
  dram_chan_if.chan chan_io  // Request in, response out
);

  import dram_addr_pkg::*;
  import dram_req_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // Word store
  // ~~~~~~~~~~~~~~~~~~~~
  logic [data_width_lp-1:0]      mem [chan_words_lp];  // Contents are never cleared
  logic [chan_addr_width_lp-1:0] word_idx;             // Word picked by the request

  // The word index is everything above the channel bits in the DRAM layout
  // The channel bits and the byte offset are dropped
  assign word_idx = chan_io.req_addr[daddr_width_lp-1 -: chan_addr_width_lp];

  always_ff @(posedge clk_i) begin
    if (chan_io.req_v && chan_io.req_we) begin
      mem[word_idx] <= chan_io.req_data;  // Write lands on this edge
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Response registers
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      chan_io.resp_v <= 1'b0;            // Quiet after reset
    end else begin
      chan_io.resp_v <= chan_io.req_v;   // Response follows the request by one cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (chan_io.req_v) begin
      chan_io.resp_we   <= chan_io.req_we;    // Echo the write flag
      chan_io.resp_addr <= chan_io.req_addr;  // Echo the hashed address
      if (chan_io.req_we) begin
        chan_io.resp_data <= '0;              // Writes return zero data
      end else begin
        chan_io.resp_data <= mem[word_idx];   // Old contents, a write on the prior edge shows
      end
    end
  end

endmodule

/* dram_req_dispatch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Request dispatcher in front of the memory channels
// Hashes the address and strobes the one channel named by the low set bits
// Adds one cycle of latency
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dram_req_dispatch (
  input  logic                                     clk_i,       // Core clock
  input  logic                                     reset_i,     // Sync reset, active high
  input  logic                                     req_v_i,     // Request strobe
  input  logic                                     req_we_i,    // Write flag
  input  dram_addr_pkg::daddr_u                    req_addr_i,  // Cache layout address
  input  logic [dram_req_pkg::data_width_lp-1:0]   req_data_i,  // Write data
  dram_chan_if.disp                                chan_o [dram_req_pkg::num_chan_lp]
);

  import dram_addr_pkg::*;
  import dram_req_pkg::*;

  daddr_u                    enc_addr;   // Request address in DRAM layout
  logic [lg_num_chan_lp-1:0] chan_sel;   // Target channel of the request
  logic                      req_we_r;   // Registered write flag
  daddr_u                    req_addr_r; // Registered DRAM layout address
  logic [data_width_lp-1:0]  req_data_r; // Registered write data

  dram_hash_encode encode (
    .addr_i (req_addr_i),
    .addr_o (enc_addr)
  );

  assign chan_sel = enc_addr.dram.set[lg_num_chan_lp-1:0];  // Low set bits pick the channel

  // ~~~~~~~~~~~~~~~~~~~~
  // Shared payload
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      req_we_r   <= req_we_i;   // Only loaded on a request
      req_addr_r <= enc_addr;   // Channels see the hashed address
      req_data_r <= req_data_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Per channel strobes
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < num_chan_lp; i++) begin : g_chan
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        chan_o[i].req_v <= 1'b0;                          // No request after reset
      end else begin
        chan_o[i].req_v <= req_v_i & (chan_sel == i);     // Exactly one channel fires
      end
    end

    assign chan_o[i].req_we   = req_we_r;    // Payload fans out to every channel
    assign chan_o[i].req_addr = req_addr_r;  // Only the strobed channel acts on it
    assign chan_o[i].req_data = req_data_r;
  end

endmodule

/* dram_hash_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Address hash decoder, purely combinational
// Restores the cache side layout from a DRAM layout address
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dram_hash_decode (
  input  dram_addr_pkg::daddr_u addr_i,  // Address in DRAM layout
  output dram_addr_pkg::daddr_u addr_o   // Address in cache layout
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Inverse swizzle
  // ~~~~~~~~~~~~~~~~~~~~

  // IN   tag | bank | slice | cce | set | block
  // OUT  tag | set | bank | slice | cce | block

  always_comb begin
    addr_o.cache.tag   = addr_i.dram.tag;    // Tag stays on top
    addr_o.cache.set   = addr_i.dram.set;    // Set climbs back under the tag
    addr_o.cache.bank  = addr_i.dram.bank;   // Bank moves down below the set
    addr_o.cache.slice = addr_i.dram.slice;  // Slice moves down below the set
    addr_o.cache.cce   = addr_i.dram.cce;    // CCE moves down below the set
    addr_o.cache.block = addr_i.dram.block;  // Offset is untouched
  end

endmodule

/* dram_hash_encode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Address hash encoder, purely combinational
// Moves a cache side address into the DRAM layout with the set bits low
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dram_hash_encode (
  input  dram_addr_pkg::daddr_u addr_i,  // Address in cache layout
  output dram_addr_pkg::daddr_u addr_o   // Address in DRAM layout
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Field swizzle
  // ~~~~~~~~~~~~~~~~~~~~

  // IN   tag | set | bank | slice | cce | block
  // OUT  tag | bank | slice | cce | set | block

  always_comb begin
    addr_o.dram.tag   = addr_i.cache.tag;    // Tag stays on top
    addr_o.dram.bank  = addr_i.cache.bank;   // Bank slides up past the set
    addr_o.dram.slice = addr_i.cache.slice;  // Slice slides up past the set
    addr_o.dram.cce   = addr_i.cache.cce;    // CCE slides up past the set
    addr_o.dram.set   = addr_i.cache.set;    // Set drops down next to the offset
    addr_o.dram.block = addr_i.cache.block;  // Offset is untouched
  end

endmodule

/* dram_chan_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Request and response bundle of one memory channel
// The dispatcher drives the request, the channel answers and the merger reads it
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface dram_chan_if;

  import dram_addr_pkg::*;
  import dram_req_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // Request side
  // ~~~~~~~~~~~~~~~~~~~~
  logic                     req_v;     // One-cycle request strobe
  logic                     req_we;    // High for a write
  daddr_u                   req_addr;  // Address in DRAM layout
  logic [data_width_lp-1:0] req_data;  // Write data

  // ~~~~~~~~~~~~~~~~~~~~
  // Response side
  // ~~~~~~~~~~~~~~~~~~~~
  logic                     resp_v;     // One-cycle response strobe
  logic                     resp_we;    // Echo of the write flag
  daddr_u                   resp_addr;  // Echo of the DRAM layout address
  logic [data_width_lp-1:0] resp_data;  // Read data, zero on a write

  // Dispatcher drives the request
  modport disp (output req_v, req_we, req_addr, req_data);

  // Channel takes the request and drives the response
  modport chan (input req_v, req_we, req_addr, req_data,
                output resp_v, resp_we, resp_addr, resp_data);

  // Merger only looks at the response
  modport merge (input resp_v, resp_we, resp_addr, resp_data);

endinterface

/* dram_req_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Channel and request geometry of the DRAM path
// Channel count, data width and the size of each channel word store
// ~~~~~~~~~~~~~~~~~~~~

package dram_req_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Channels
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int num_chan_lp    = 4;  // Identical memory channels
  localparam int lg_num_chan_lp = 2;  // Width of a channel index

  // ~~~~~~~~~~~~~~~~~~~~
  // Request payload
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int data_width_lp = 32;  // One data word per block address

  // Word index bits sit above the channel index and above the byte offset
  localparam int chan_addr_width_lp = dram_addr_pkg::daddr_width_lp
                                      - dram_addr_pkg::block_offset_width_lp
                                      - lg_num_chan_lp;

  // Each channel keeps one word for every block address it owns
  localparam int chan_words_lp = 1 << chan_addr_width_lp;

endpackage

/* dram_addr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Address geometry of the DRAM path behind the cache address hash
// Gives the field widths and one address word read in cache and DRAM layouts
// ~~~~~~~~~~~~~~~~~~~~

package dram_addr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Field widths
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int daddr_width_lp        = 12;  // Full block address width
  localparam int block_offset_width_lp = 3;   // Byte offset inside an 8-byte block
  localparam int set_width_lp          = 3;   // Cache set index
  localparam int bank_width_lp         = 1;   // Bank index inside a slice
  localparam int slice_width_lp        = 1;   // Slice index inside a CCE
  localparam int cce_width_lp          = 1;   // CCE index

  // The tag takes whatever is left above the other fields
  localparam int tag_width_lp = daddr_width_lp - block_offset_width_lp - set_width_lp
                                - bank_width_lp - slice_width_lp - cce_width_lp;

  // ~~~~~~~~~~~~~~~~~~~~
  // Address layouts
  // ~~~~~~~~~~~~~~~~~~~~

  // Cache side order with the set index right under the tag
  typedef struct packed {
    logic [tag_width_lp-1:0]          tag;    // Upper address bits
    logic [set_width_lp-1:0]          set;    // Set index
    logic [bank_width_lp-1:0]         bank;   // Bank select
    logic [slice_width_lp-1:0]        slice;  // Slice select
    logic [cce_width_lp-1:0]          cce;    // CCE select
    logic [block_offset_width_lp-1:0] block;  // Byte offset
  } cache_addr_s;

  // DRAM side order puts the set index just above the block offset
  // Consecutive sets then land in different memory channels
  typedef struct packed {
    logic [tag_width_lp-1:0]          tag;    // Upper address bits
    logic [bank_width_lp-1:0]         bank;   // Bank select
    logic [slice_width_lp-1:0]        slice;  // Slice select
    logic [cce_width_lp-1:0]          cce;    // CCE select
    logic [set_width_lp-1:0]          set;    // Set index, low bits pick the channel
    logic [block_offset_width_lp-1:0] block;  // Byte offset
  } dram_addr_s;

  // One address word seen through either layout
  typedef union packed {
    cache_addr_s cache;  // Cache side view
    dram_addr_s  dram;   // DRAM side view
  } daddr_u;

endpackage
